/* Makefile */
VERILATOR ?= verilator
TOP       := dcache_tb
FILELIST  := build.f
VFLAGS    := --binary --timing --assert -j 0
SIM_ARGS  := +verilator+error+limit+100
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
hw/dcache_cfg_pkg.sv
hw/dcache_bus_pkg.sv
hw/dcache_tag_array.sv
hw/dcache_data_array.sv
hw/dcache_miss_engine.sv
hw/dcache_lookup_pipe.sv
hw/dcache_top.sv
tests/dcache_assertions.sv
tests/dcache_tb.sv

/* hw/dcache_bus_pkg.sv */
// core-side and memory-side transfer types of the data cache
// plus the miss engine state encoding
package dcache_bus_pkg;

  typedef enum logic {
    LOAD,
    STORE
  } mem_op_e;

  typedef enum logic [1:0] {
    SIZE_B,
    SIZE_H,
    SIZE_W
  } access_size_e;

  typedef struct packed {
    mem_op_e                op;
    access_size_e           size;
    logic                   is_unsigned;
    dcache_cfg_pkg::paddr_t addr;
    dcache_cfg_pkg::word_t  wdata;
  } core_req_t;

  typedef struct packed {
    dcache_cfg_pkg::word_t rdata;
    logic                  err;
  } core_rsp_t;

  // cache to memory, AXI-style channels without id or len
  typedef struct packed {
    logic                   aw_valid;
    dcache_cfg_pkg::paddr_t aw_addr;
    logic                   w_valid;
    dcache_cfg_pkg::word_t  w_data;
    logic                   w_last;
    logic                   b_ready;
    logic                   ar_valid;
    dcache_cfg_pkg::paddr_t ar_addr;
    logic                   r_ready;
  } mem_req_t;

  typedef struct packed {
    logic                  aw_ready;
    logic                  w_ready;
    logic                  b_valid;
    logic                  ar_ready;
    logic                  r_valid;
    dcache_cfg_pkg::word_t r_data;
    logic                  r_last;
  } mem_rsp_t;

  typedef enum logic [2:0] {
    IDLE,
    WB_ADDR,
    WB_DATA,
    WB_RESP,
    RD_ADDR,
    RD_DATA
  } miss_state_e;

endpackage

/* hw/dcache_cfg_pkg.sv */
// data cache geometry, 2 ways x 16 sets x 16-byte lines
// address field types and field extraction helpers
package dcache_cfg_pkg;

  localparam int WAY_NUM        = 2;
  localparam int SET_NUM        = 16;
  localparam int LINE_WORDS     = 4;
  localparam int OFS_WIDTH      = $clog2(LINE_WORDS * 4);
  localparam int IDX_WIDTH      = $clog2(SET_NUM);
  localparam int TAG_WIDTH      = 32 - IDX_WIDTH - OFS_WIDTH;
  localparam int WORD_SEL_WIDTH = $clog2(LINE_WORDS);

  typedef logic [31:0]                  paddr_t;
  typedef logic [31:0]                  word_t;
  typedef logic [TAG_WIDTH-1:0]         tag_t;
  typedef logic [IDX_WIDTH-1:0]         idx_t;
  typedef logic [LINE_WORDS-1:0][31:0]  line_t;
  typedef logic [$clog2(WAY_NUM)-1:0]   way_t;

  // address field slices
  function automatic tag_t tag_of(paddr_t addr);
    return addr[31 -: TAG_WIDTH];
  endfunction

  function automatic idx_t idx_of(paddr_t addr);
    return addr[OFS_WIDTH +: IDX_WIDTH];
  endfunction

  function automatic logic [WORD_SEL_WIDTH-1:0] word_of(paddr_t addr);
    return addr[2 +: WORD_SEL_WIDTH];
  endfunction

endpackage

/* hw/dcache_data_array.sv */
`timescale 1ns/10ps
// line storage per way, byte-merge store write and whole-line refill
module dcache_data_array (
  input  logic                   clk,
  input  dcache_cfg_pkg::paddr_t lookup_addr_i,
  input  dcache_cfg_pkg::way_t   hit_way_i,
  input  logic                   store_en_i,
  input  logic [3:0]             store_be_i,
  input  dcache_cfg_pkg::word_t  store_data_i,
  input  logic                   refill_en_i,
  input  dcache_cfg_pkg::way_t   refill_way_i,
  input  dcache_cfg_pkg::line_t  refill_line_i,
  input  dcache_cfg_pkg::way_t   victim_way_i,
  output dcache_cfg_pkg::line_t  line_o,
  output dcache_cfg_pkg::line_t  victim_line_o
);
  import dcache_cfg_pkg::*;

  line_t                     mem_q [WAY_NUM][SET_NUM];
  idx_t                      idx;
  logic [WORD_SEL_WIDTH-1:0] word_sel;

  assign idx      = idx_of(lookup_addr_i);
  assign word_sel = word_of(lookup_addr_i);

  // combinational read at the stage-1 index
  assign line_o        = mem_q[hit_way_i][idx];
  assign victim_line_o = mem_q[victim_way_i][idx];

  always_ff @(posedge clk) begin
    if (refill_en_i) begin
      mem_q[refill_way_i][idx] <= refill_line_i;
    end else if (store_en_i) begin
      // only the enabled byte lanes of the hit word
      for (int b = 0; b < 4; b++) begin
        if (store_be_i[b]) begin
          mem_q[hit_way_i][idx][word_sel][8*b +: 8] <= store_data_i[8*b +: 8];
        end
      end
    end
  end

endmodule

/* hw/dcache_lookup_pipe.sv */
`timescale 1ns/10ps
// request acceptance, alignment check and stage-1 hit/miss handling
module dcache_lookup_pipe (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      req_valid_i,
  input  dcache_bus_pkg::core_req_t req_i,
  output logic                      req_ready_o,
  output logic                      rsp_valid_o,
  output dcache_bus_pkg::core_rsp_t rsp_o,
  input  logic                      hit_i,
  input  dcache_cfg_pkg::way_t      hit_way_i,
  input  dcache_cfg_pkg::way_t      victim_way_i,
  input  logic                      victim_dirty_i,
  input  logic                      victim_valid_i,
  input  dcache_cfg_pkg::line_t     line_i,
  input  logic                      refill_done_i,
  output dcache_cfg_pkg::paddr_t    lookup_addr_o,
  output logic                      lookup_valid_o,
  output logic                      store_en_o,
  output logic [3:0]                store_be_o,
  output dcache_cfg_pkg::word_t     store_data_o,
  output logic                      miss_start_o
);
  import dcache_cfg_pkg::*;
  import dcache_bus_pkg::*;

  logic      s1_valid;
  logic      s1_err;
  core_req_t s1_req;
  logic      miss_busy_q;
  logic      misaligned;
  logic      s1_lookup;
  logic      s1_miss;
  logic      s1_hit;
  logic [1:0] byte_ofs;
  word_t     hit_word;
  word_t     shifted;

  // ====================
  // stage 0: alignment
  always_comb begin
    case (req_i.size)
      SIZE_H:  misaligned = req_i.addr[0];
      SIZE_W:  misaligned = |req_i.addr[1:0];
      default: misaligned = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid    <= 1'b0;
      s1_err      <= 1'b0;
      miss_busy_q <= 1'b0;
    end else begin
      if (req_ready_o) begin
        s1_valid <= req_valid_i;
        s1_err   <= misaligned;
      end
      if (miss_start_o) begin
        miss_busy_q <= 1'b1;
      end else if (refill_done_i) begin
        miss_busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_ready_o && req_valid_i) begin
      s1_req <= req_i;
    end
  end

  // ====================
  // stage 1: hit or miss
  assign s1_lookup = s1_valid && !s1_err;
  assign s1_hit    = hit_i;
  assign s1_miss   = s1_lookup && !s1_hit;

  assign req_ready_o    = !s1_miss;
  assign miss_start_o   = s1_miss && !miss_busy_q;
  assign lookup_addr_o  = s1_req.addr;
  assign lookup_valid_o = s1_lookup;

  assign byte_ofs = s1_req.addr[1:0];

  // store lanes
  assign store_en_o = s1_lookup && s1_hit && (s1_req.op == STORE);
  always_comb begin
    case (s1_req.size)
      SIZE_B: begin
        store_be_o   = 4'b0001 << byte_ofs;
        store_data_o = {4{s1_req.wdata[7:0]}};
      end
      SIZE_H: begin
        store_be_o   = 4'b0011 << byte_ofs;
        store_data_o = {2{s1_req.wdata[15:0]}};
      end
      default: begin
        store_be_o   = 4'b1111;
        store_data_o = s1_req.wdata;
      end
    endcase
  end

  // load extraction and extension
  assign hit_word = line_i[word_of(s1_req.addr)];
  assign shifted  = hit_word >> {byte_ofs, 3'b000};

  always_comb begin
    rsp_o.err = s1_err;
    case (s1_req.size)
      SIZE_B:  rsp_o.rdata = {{24{!s1_req.is_unsigned && shifted[7]}}, shifted[7:0]};
      SIZE_H:  rsp_o.rdata = {{16{!s1_req.is_unsigned && shifted[15]}}, shifted[15:0]};
      default: rsp_o.rdata = hit_word;
    endcase
    if (s1_err) begin
      rsp_o.rdata = '0;
    end
  end

  assign rsp_valid_o = s1_valid && (s1_err || s1_hit);

endmodule

/* hw/dcache_miss_engine.sv */
`timescale 1ns/10ps
// miss handling FSM: dirty victim write-back burst, then line refill burst
module dcache_miss_engine (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     miss_start_i,
  input  dcache_cfg_pkg::paddr_t   miss_addr_i,
  input  dcache_cfg_pkg::way_t     victim_way_i,
  input  dcache_cfg_pkg::tag_t     victim_tag_i,
  input  logic                     victim_dirty_i,
  input  logic                     victim_valid_i,
  input  dcache_cfg_pkg::line_t    victim_line_i,
  input  dcache_bus_pkg::mem_rsp_t mem_rsp_i,
  output dcache_bus_pkg::mem_req_t mem_req_o,
  output logic                     refill_en_o,
  output dcache_cfg_pkg::way_t     refill_way_o,
  output dcache_cfg_pkg::line_t    refill_line_o,
  output logic                     refill_done_o
);
  import dcache_cfg_pkg::*;
  import dcache_bus_pkg::*;

  localparam logic [WORD_SEL_WIDTH-1:0] LAST_BEAT = WORD_SEL_WIDTH'(LINE_WORDS - 1);

  miss_state_e               state_q;
  logic [WORD_SEL_WIDTH-1:0] beat_q;
  way_t                      way_q;
  paddr_t                    wb_addr_q;
  paddr_t                    rd_addr_q;
  line_t                     rd_buf_q;
  logic                      w_fire;
  logic                      r_fire;

  assign w_fire = (state_q == WB_DATA) && mem_rsp_i.w_ready;
  assign r_fire = (state_q == RD_DATA) && mem_rsp_i.r_valid;

  // ====================
  // state and beat count
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      beat_q  <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          beat_q <= '0;
          if (miss_start_i) begin
            state_q <= (victim_valid_i && victim_dirty_i) ? WB_ADDR : RD_ADDR;
          end
        end
        WB_ADDR: if (mem_rsp_i.aw_ready) state_q <= WB_DATA;
        WB_DATA: begin
          if (w_fire) begin
            beat_q <= beat_q + 1'b1;
            if (beat_q == LAST_BEAT) begin
              state_q <= WB_RESP;
            end
          end
        end
        WB_RESP: if (mem_rsp_i.b_valid) state_q <= RD_ADDR;
        RD_ADDR: if (mem_rsp_i.ar_ready) state_q <= RD_DATA;
        RD_DATA: begin
          if (r_fire) begin
            beat_q <= beat_q + 1'b1;
            if (mem_rsp_i.r_last) begin
              state_q <= IDLE;
            end
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // victim and line addresses, captured at miss start
  always_ff @(posedge clk) begin
    if (state_q == IDLE && miss_start_i) begin
      way_q     <= victim_way_i;
      wb_addr_q <= {victim_tag_i, idx_of(miss_addr_i), {OFS_WIDTH{1'b0}}};
      rd_addr_q <= {miss_addr_i[31:OFS_WIDTH], {OFS_WIDTH{1'b0}}};
    end
    if (r_fire) begin
      rd_buf_q[beat_q] <= mem_rsp_i.r_data;
    end
  end

  // ====================
  // bus drive
  always_comb begin
    mem_req_o          = '0;
    mem_req_o.aw_valid = (state_q == WB_ADDR);
    mem_req_o.aw_addr  = wb_addr_q;
    mem_req_o.w_valid  = (state_q == WB_DATA);
    mem_req_o.w_data   = victim_line_i[beat_q];
    mem_req_o.w_last   = (state_q == WB_DATA) && (beat_q == LAST_BEAT);
    mem_req_o.b_ready  = (state_q == WB_RESP);
    mem_req_o.ar_valid = (state_q == RD_ADDR);
    mem_req_o.ar_addr  = rd_addr_q;
    mem_req_o.r_ready  = (state_q == RD_DATA);
  end

  // last beat goes straight into the line write
  always_comb begin
    refill_line_o         = rd_buf_q;
    refill_line_o[beat_q] = mem_rsp_i.r_data;
  end

  assign refill_en_o   = r_fire && mem_rsp_i.r_last;
  assign refill_done_o = refill_en_o;
  assign refill_way_o  = way_q;

endmodule

/* hw/dcache_tag_array.sv */
`timescale 1ns/10ps
// tag, valid and dirty storage per way and set, with PLRU victim choice
module dcache_tag_array (
  input  logic                   clk,
  input  logic                   rst_n,
  input  dcache_cfg_pkg::paddr_t lookup_addr_i,
  input  logic                   lookup_valid_i,
  input  logic                   store_en_i,
  input  logic                   refill_en_i,
  input  dcache_cfg_pkg::way_t   refill_way_i,
  output logic                   hit_o,
  output dcache_cfg_pkg::way_t   hit_way_o,
  output dcache_cfg_pkg::way_t   victim_way_o,
  output dcache_cfg_pkg::tag_t   victim_tag_o,
  output logic                   victim_valid_o,
  output logic                   victim_dirty_o
);
  import dcache_cfg_pkg::*;

  tag_t                            tag_q [WAY_NUM][SET_NUM];
  logic [WAY_NUM-1:0][SET_NUM-1:0] valid_q;
  logic [WAY_NUM-1:0][SET_NUM-1:0] dirty_q;
  logic [SET_NUM-1:0]              plru_q;
  logic [WAY_NUM-1:0]              match;
  idx_t                            idx;
  tag_t                            tag;

  assign idx = idx_of(lookup_addr_i);
  assign tag = tag_of(lookup_addr_i);

  // ====================
  // tag compare
  always_comb begin
    hit_way_o = '0;
    for (int w = 0; w < WAY_NUM; w++) begin
      match[w] = valid_q[w][idx] && (tag_q[w][idx] == tag);
      if (match[w]) begin
        hit_way_o = way_t'(w);
      end
    end
  end

  assign hit_o = |match;

  // plru bit names the way to replace
  assign victim_way_o   = way_t'(plru_q[idx]);
  assign victim_tag_o   = tag_q[victim_way_o][idx];
  assign victim_valid_o = valid_q[victim_way_o][idx];
  assign victim_dirty_o = dirty_q[victim_way_o][idx];

  always_ff @(posedge clk) begin
    if (refill_en_i) begin
      tag_q[refill_way_i][idx] <= tag;
    end
  end

  // ====================
  // line state and plru
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
      dirty_q <= '0;
      plru_q  <= '0;
    end else begin
      if (refill_en_i) begin
        valid_q[refill_way_i][idx] <= 1'b1;
        dirty_q[refill_way_i][idx] <= 1'b0;
      end else if (store_en_i) begin
        dirty_q[hit_way_o][idx] <= 1'b1;
      end
      // point at the way not just used
      if (lookup_valid_i && hit_o) begin
        plru_q[idx] <= (hit_way_o == '0);
      end
    end
  end

endmodule

/* hw/dcache_top.sv */
`timescale 1ns/10ps
// write-back data cache top, lookup pipe plus arrays plus miss engine
module dcache_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      req_valid_i,
  input  dcache_bus_pkg::core_req_t req_i,
  output logic                      req_ready_o,
  output logic                      rsp_valid_o,
  output dcache_bus_pkg::core_rsp_t rsp_o,
  output dcache_bus_pkg::mem_req_t  mem_req_o,
  input  dcache_bus_pkg::mem_rsp_t  mem_rsp_i
);
  import dcache_cfg_pkg::*;

  paddr_t     lookup_addr;
  logic       lookup_valid;
  logic       hit;
  way_t       hit_way;
  way_t       victim_way;
  tag_t       victim_tag;
  logic       victim_valid;
  logic       victim_dirty;
  line_t      line;
  line_t      victim_line;
  logic       store_en;
  logic [3:0] store_be;
  word_t      store_data;
  logic       miss_start;
  logic       refill_en;
  way_t       refill_way;
  line_t      refill_line;
  logic       refill_done;

  dcache_lookup_pipe u_pipe (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_valid_i    (req_valid_i),
    .req_i          (req_i),
    .req_ready_o    (req_ready_o),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_o          (rsp_o),
    .hit_i          (hit),
    .hit_way_i      (hit_way),
    .victim_way_i   (victim_way),
    .victim_dirty_i (victim_dirty),
    .victim_valid_i (victim_valid),
    .line_i         (line),
    .refill_done_i  (refill_done),
    .lookup_addr_o  (lookup_addr),
    .lookup_valid_o (lookup_valid),
    .store_en_o     (store_en),
    .store_be_o     (store_be),
    .store_data_o   (store_data),
    .miss_start_o   (miss_start)
  );

  dcache_tag_array u_tags (
    .clk            (clk),
    .rst_n          (rst_n),
    .lookup_addr_i  (lookup_addr),
    .lookup_valid_i (lookup_valid),
    .store_en_i     (store_en),
    .refill_en_i    (refill_en),
    .refill_way_i   (refill_way),
    .hit_o          (hit),
    .hit_way_o      (hit_way),
    .victim_way_o   (victim_way),
    .victim_tag_o   (victim_tag),
    .victim_valid_o (victim_valid),
    .victim_dirty_o (victim_dirty)
  );

  // write-back reads the way captured by the miss engine
  dcache_data_array u_data (
    .clk           (clk),
    .lookup_addr_i (lookup_addr),
    .hit_way_i     (hit_way),
    .store_en_i    (store_en),
    .store_be_i    (store_be),
    .store_data_i  (store_data),
    .refill_en_i   (refill_en),
    .refill_way_i  (refill_way),
    .refill_line_i (refill_line),
    .victim_way_i  (refill_way),
    .line_o        (line),
    .victim_line_o (victim_line)
  );

  dcache_miss_engine u_miss (
    .clk            (clk),
    .rst_n          (rst_n),
    .miss_start_i   (miss_start),
    .miss_addr_i    (lookup_addr),
    .victim_way_i   (victim_way),
    .victim_tag_i   (victim_tag),
    .victim_dirty_i (victim_dirty),
    .victim_valid_i (victim_valid),
    .victim_line_i  (victim_line),
    .mem_rsp_i      (mem_rsp_i),
    .mem_req_o      (mem_req_o),
    .refill_en_o    (refill_en),
    .refill_way_o   (refill_way),
    .refill_line_o  (refill_line),
    .refill_done_o  (refill_done)
  );

endmodule

/* tests/dcache_assertions.sv */
`timescale 1ns/10ps
// memory-bus protocol and reset checks for the data cache top
module dcache_assertions (
  input logic                     clk,
  input logic                     rst_n,
  input logic                     rsp_valid_i,
  input dcache_bus_pkg::mem_req_t mem_req_i,
  input dcache_bus_pkg::mem_rsp_t mem_rsp_i
);

  // read by the testbench at the end of the run
  int fail_cnt = 0;

  // ====================
  // valid holds with a stable payload until ready
  a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_i.aw_valid && !mem_rsp_i.aw_ready
      |=> mem_req_i.aw_valid && $stable(mem_req_i.aw_addr))
    else begin
      fail_cnt++;
      $error("aw_valid or aw_addr changed before aw_ready");
    end

  a_w_hold: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_i.w_valid && !mem_rsp_i.w_ready
      |=> mem_req_i.w_valid && $stable(mem_req_i.w_data) && $stable(mem_req_i.w_last))
    else begin
      fail_cnt++;
      $error("w_valid or write beat changed before w_ready");
    end

  a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_i.ar_valid && !mem_rsp_i.ar_ready
      |=> mem_req_i.ar_valid && $stable(mem_req_i.ar_addr))
    else begin
      fail_cnt++;
      $error("ar_valid or ar_addr changed before ar_ready");
    end

  // refill and write-back never overlap
  a_no_rw_overlap: assert property (@(posedge clk) disable iff (!rst_n)
    !(mem_req_i.r_ready && mem_req_i.w_valid))
    else begin
      fail_cnt++;
      $error("r_ready high together with w_valid");
    end

  a_reset_quiet: assert property (@(posedge clk)
    !rst_n |-> !rsp_valid_i && !mem_req_i.aw_valid && !mem_req_i.w_valid
      && !mem_req_i.ar_valid)
    else begin
      fail_cnt++;
      $error("response or memory valid high during reset");
    end

endmodule

bind dcache_top dcache_assertions u_assert (
  .clk         (clk),
  .rst_n       (rst_n),
  .rsp_valid_i (rsp_valid_o),
  .mem_req_i   (mem_req_o),
  .mem_rsp_i   (mem_rsp_i)
);

/* tests/dcache_tb.sv */
`timescale 1ns/10ps
// data cache testbench, random loads and stores against a byte model
// with a memory-bus responder behind the cache
module dcache_tb;
  import dcache_cfg_pkg::*;
  import dcache_bus_pkg::*;

  localparam int NUM_REQS       = 2000;
  localparam int WINDOW_BYTES   = 1024;
  localparam int TIMEOUT_CYCLES = NUM_REQS * 40;
  localparam int SEED           = 31;

  typedef struct packed {
    logic      check_data;
    core_rsp_t rsp;
  } exp_rsp_t;

  logic      clk = 1'b0;
  logic      rst_n;
  logic      req_valid;
  core_req_t req;
  logic      req_ready;
  logic      rsp_valid;
  core_rsp_t rsp;
  mem_req_t  mem_req;
  mem_rsp_t  mem_rsp = '0;

  // architectural view and the memory behind the cache
  logic [7:0] model_mem [WINDOW_BYTES];
  logic [7:0] mem_bytes [WINDOW_BYTES];
  exp_rsp_t   expected_q [$];

  mem_rsp_t rsp_next = '0;
  logic     aw_rdy = 1'b0;
  logic     w_rdy = 1'b0;
  logic     ar_rdy = 1'b0;
  int       aw_gap = 0;
  int       w_gap = 0;
  int       ar_gap = 0;
  paddr_t   wb_addr;
  paddr_t   rd_addr;
  int       wb_beat = 0;
  int       rd_beat = 0;
  int       wb_count = 0;
  int       rd_count = 0;
  int       errors = 0;
  int       issued = 0;
  int       rsp_cnt = 0;
  int       cycle_cnt = 0;
  logic     accepted;

  always #2 clk = ~clk;

  dcache_top uut (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_valid),
    .req_i       (req),
    .req_ready_o (req_ready),
    .rsp_valid_o (rsp_valid),
    .rsp_o       (rsp),
    .mem_req_o   (mem_req),
    .mem_rsp_i   (mem_rsp)
  );

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  function automatic logic [7:0] fill_byte(int a);
    return 8'((a * 13) ^ (a >> 3));
  endfunction

  function automatic word_t model_word(int a);
    return {model_mem[a + 3], model_mem[a + 2], model_mem[a + 1], model_mem[a]};
  endfunction

  function automatic word_t mem_word(int a);
    return {mem_bytes[a + 3], mem_bytes[a + 2], mem_bytes[a + 1], mem_bytes[a]};
  endfunction

  function automatic logic line_ok(paddr_t a);
    return (a[3:0] == 4'h0) && (a < paddr_t'(WINDOW_BYTES));
  endfunction

  function automatic logic is_misaligned(core_req_t r);
    case (r.size)
      SIZE_H:  return r.addr[0];
      SIZE_W:  return r.addr[1:0] != 2'b00;
      default: return 1'b0;
    endcase
  endfunction

  // little-endian load with sign or zero extension
  function automatic word_t expect_load(core_req_t r);
    int i;
    i = int'(r.addr[9:0]);
    case (r.size)
      SIZE_B:  return {{24{!r.is_unsigned && model_mem[i][7]}}, model_mem[i]};
      SIZE_H:  return {{16{!r.is_unsigned && model_mem[i + 1][7]}},
                       model_mem[i + 1], model_mem[i]};
      default: return model_word(i);
    endcase
  endfunction

  task automatic apply_store(core_req_t r);
    int i;
    int n;
    i = int'(r.addr[9:0]);
    n = (r.size == SIZE_B) ? 1 : (r.size == SIZE_H) ? 2 : 4;
    for (int b = 0; b < n; b++) begin
      model_mem[i + b] = r.wdata[8*b +: 8];
    end
  endtask

  task automatic make_request(output core_req_t r);
    r.op          = mem_op_e'($urandom_range(1, 0));
    r.size        = access_size_e'($urandom_range(2, 0));
    r.is_unsigned = 1'($urandom_range(1, 0));
    r.addr        = paddr_t'($urandom_range(WINDOW_BYTES - 1, 0));
    r.wdata       = $urandom();
    // mostly aligned, some misaligned on purpose
    if ($urandom_range(7, 0) != 0) begin
      case (r.size)
        SIZE_H:  r.addr[0] = 1'b0;
        SIZE_W:  r.addr[1:0] = 2'b00;
        default: ;
      endcase
    end
  endtask

  task automatic record_accept(core_req_t r);
    exp_rsp_t e;
    logic     bad;
    bad          = is_misaligned(r);
    e.check_data = (r.op == LOAD) && !bad;
    e.rsp.err    = bad;
    e.rsp.rdata  = e.check_data ? expect_load(r) : '0;
    expected_q.push_back(e);
    if (r.op == STORE && !bad) begin
      apply_store(r);
    end
    issued++;
  endtask

  task automatic check_response();
    exp_rsp_t e;
    if (rsp_valid) begin
      rsp_cnt++;
      if (expected_q.size() == 0) begin
        errors++;
        $display("response %0d arrived with no request outstanding", rsp_cnt);
      end else begin
        e = expected_q.pop_front();
        check_value("rsp.err", 32'(rsp.err), 32'(e.rsp.err));
        if (e.check_data) begin
          check_value("rsp.rdata", rsp.rdata, e.rsp.rdata);
        end
      end
    end
  endtask

  task automatic pace_ready(input logic valid, inout logic rdy, inout int gap);
    if (valid && rdy) begin
      rdy = 1'b0;
      gap = $urandom_range(3, 0);
    end else if (valid) begin
      if (gap == 0) begin
        rdy = 1'b1;
      end else begin
        gap--;
      end
    end
  endtask

  // write-back beats must match the model line
  task automatic serve_write();
    int ofs;
    if (mem_req.aw_valid && mem_rsp.aw_ready) begin
      wb_addr = mem_req.aw_addr;
      wb_beat = 0;
      wb_count++;
      if (!line_ok(wb_addr)) begin
        errors++;
        $display("write-back address %h is not a line inside the test window", wb_addr);
      end
    end
    if (mem_req.w_valid && mem_rsp.w_ready) begin
      ofs = int'(wb_addr[9:0]) + 4 * wb_beat;
      check_value("w_data", mem_req.w_data, model_word(ofs));
      check_value("w_last", 32'(mem_req.w_last), 32'(wb_beat == 3));
      for (int b = 0; b < 4; b++) begin
        mem_bytes[ofs + b] = mem_req.w_data[8*b +: 8];
      end
      wb_beat++;
      rsp_next.b_valid = (wb_beat == 4);
    end
    if (mem_req.b_ready && mem_rsp.b_valid) begin
      rsp_next.b_valid = 1'b0;
    end
  endtask

  task automatic serve_read();
    if (mem_req.ar_valid && mem_rsp.ar_ready) begin
      rd_addr = mem_req.ar_addr;
      rd_beat = 0;
      rd_count++;
      if (!line_ok(rd_addr)) begin
        errors++;
        $display("refill address %h is not a line inside the test window", rd_addr);
      end
      rsp_next.r_valid = 1'b1;
    end else if (mem_req.r_ready && mem_rsp.r_valid) begin
      rd_beat++;
      rsp_next.r_valid = (rd_beat < 4);
    end
    if (rsp_next.r_valid) begin
      rsp_next.r_data = mem_word(int'(rd_addr[9:0]) + 4 * rd_beat);
      rsp_next.r_last = (rd_beat == 3);
    end else begin
      rsp_next.r_last = 1'b0;
    end
  endtask

  // ====================
  // responses and memory bus, sampled mid-cycle
  always begin
    @(negedge clk);
    if (rst_n) begin
      check_response();
      serve_write();
      serve_read();
      pace_ready(mem_req.aw_valid, aw_rdy, aw_gap);
      pace_ready(mem_req.w_valid, w_rdy, w_gap);
      pace_ready(mem_req.ar_valid, ar_rdy, ar_gap);
      rsp_next.aw_ready = aw_rdy;
      rsp_next.w_ready  = w_rdy;
      rsp_next.ar_ready = ar_rdy;
    end
    @(posedge clk);
    #1;
    mem_rsp = rsp_next;
  end

  initial begin
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles with %0d of %0d requests answered",
             cycle_cnt, rsp_cnt, NUM_REQS);
    $display("test failed");
    $finish;
  end

  // ====================
  // stimulus
  initial begin
    void'($urandom(SEED));
    for (int a = 0; a < WINDOW_BYTES; a++) begin
      model_mem[a] = fill_byte(a);
      mem_bytes[a] = fill_byte(a);
    end
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    while (issued < NUM_REQS) begin
      @(negedge clk);
      accepted = req_valid && req_ready;
      if (accepted) begin
        record_accept(req);
      end
      @(posedge clk);
      #1;
      // occasional idle cycles between requests
      if ((accepted || !req_valid) && issued < NUM_REQS) begin
        req_valid = ($urandom_range(7, 0) != 0);
        if (req_valid) begin
          make_request(req);
        end
      end else if (accepted) begin
        req_valid = 1'b0;
      end
    end

    while (expected_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (8) @(negedge clk);
    check_value("response count", 32'(rsp_cnt), 32'(issued));

    $display("errors %0d, assertion failures %0d, requests %0d, write-backs %0d, refills %0d",
             errors, uut.u_assert.fail_cnt, issued, wb_count, rd_count);
    if (errors == 0 && uut.u_assert.fail_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
